/* verilog/mem_pkg.sv */
package mem_pkg;

  // word and address geometry of the core
  localparam int DATA_WIDTH = 16;
  localparam int BANK_BITS  = 2;
  localparam int ROW_BITS   = 4;

  localparam int NUM_BANKS  = 1 << BANK_BITS;
  localparam int NUM_ROWS   = 1 << ROW_BITS;

  // the bank field sits above the row field
  localparam int ADDR_BITS  = BANK_BITS + ROW_BITS;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_BITS-1:0]  addr_t;
  typedef logic [BANK_BITS-1:0]  bank_t;
  typedef logic [ROW_BITS-1:0]   row_t;

  // sweep clears every row once, then the core runs
  typedef enum logic [0:0] {
    st_sweep = 1'b0,
    st_run   = 1'b1
  } init_state_t;

endpackage

/* verilog/bank_init.sv */
`timescale 1ns/10ps

module bank_init (
  input  logic          clk,
  input  logic          rst,
  output logic          ready,
  output logic          init_write,
  output mem_pkg::row_t init_row
);

  mem_pkg::init_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mem_pkg::st_sweep;
      init_row <= '0;
    end else if (state == mem_pkg::st_sweep) begin
      init_row <= init_row + 1'b1;
      // last row is written in this cycle, so the core runs from the next one
      if (init_row == mem_pkg::row_t'(mem_pkg::NUM_ROWS - 1)) begin
        state <= mem_pkg::st_run;
      end
    end
  end

  // the sweep owns the write path until it ends
  assign init_write = (state == mem_pkg::st_sweep);
  assign ready      = (state == mem_pkg::st_run);

endmodule

/* verilog/bank_array.sv */
`timescale 1ns/10ps

module bank_array #(
  parameter int SRAM_DELAY   = 2,
  parameter int NUM_RD_PORTS = 2
) (
  input  logic           clk,
  input  logic           init_write,
  input  mem_pkg::row_t  init_row,
  input  logic           wr_en,
  input  mem_pkg::bank_t wr_bank,
  input  mem_pkg::row_t  wr_row,
  input  mem_pkg::data_t wr_data,
  input  logic           rd_en     [NUM_RD_PORTS],
  input  mem_pkg::bank_t rd_bank   [NUM_RD_PORTS],
  input  mem_pkg::row_t  rd_row    [NUM_RD_PORTS],
  output mem_pkg::data_t bank_dout [NUM_RD_PORTS][mem_pkg::NUM_BANKS]
);

  // one replica per read port and bank, all replicas of a bank hold the same data
  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port
    for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_bank

      mem_pkg::data_t mem [mem_pkg::NUM_ROWS];
      mem_pkg::data_t dly [SRAM_DELAY];
      logic           wr_hit;
      logic           rd_hit;

      assign wr_hit = wr_en && (wr_bank == mem_pkg::bank_t'(b));
      assign rd_hit = rd_en[p] && (rd_bank[p] == mem_pkg::bank_t'(b));

      // sweep writes clear the same row in every bank
      always_ff @(posedge clk) begin
        if (init_write) begin
          mem[init_row] <= '0;
        end else if (wr_hit) begin
          mem[wr_row] <= wr_data;
        end
      end

      // read-first: the nonblocking read sees the array before this cycle's write
      always_ff @(posedge clk) begin
        if (rd_hit) begin
          dly[0] <= mem[rd_row[p]];
        end
      end

      // remaining SRAM_DELAY-1 stages of the read pipeline
      always_ff @(posedge clk) begin
        for (int s = 1; s < SRAM_DELAY; s++) begin
          dly[s] <= dly[s-1];
        end
      end

      assign bank_dout[p][b] = dly[SRAM_DELAY-1];

    end
  end

endmodule

/* verilog/read_tracker.sv */
`timescale 1ns/10ps

module read_tracker #(
  parameter int SRAM_DELAY   = 2,
  parameter int NUM_RD_PORTS = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_en     [NUM_RD_PORTS],
  input  mem_pkg::bank_t rd_bank   [NUM_RD_PORTS],
  input  mem_pkg::row_t  rd_row    [NUM_RD_PORTS],
  input  logic           wr_en,
  input  mem_pkg::bank_t wr_bank,
  input  mem_pkg::row_t  wr_row,
  input  mem_pkg::data_t wr_data,
  output logic           trk_valid [NUM_RD_PORTS],
  output mem_pkg::bank_t trk_bank  [NUM_RD_PORTS],
  output logic           trk_fwd   [NUM_RD_PORTS],
  output mem_pkg::data_t trk_data  [NUM_RD_PORTS]
);

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port

    logic           vld_q  [SRAM_DELAY];
    mem_pkg::bank_t bank_q [SRAM_DELAY];
    mem_pkg::row_t  row_q  [SRAM_DELAY];
    logic           fwd_q  [SRAM_DELAY];
    mem_pkg::data_t data_q [SRAM_DELAY];

    logic           vld_n  [SRAM_DELAY];
    mem_pkg::bank_t bank_n [SRAM_DELAY];
    mem_pkg::row_t  row_n  [SRAM_DELAY];
    logic           fwd_n  [SRAM_DELAY];
    mem_pkg::data_t data_n [SRAM_DELAY];

    always_comb begin
      // entry stage takes the new read, later stages shift
      vld_n[0]  = rd_en[p];
      bank_n[0] = rd_bank[p];
      row_n[0]  = rd_row[p];
      fwd_n[0]  = 1'b0;
      data_n[0] = '0;
      for (int s = 1; s < SRAM_DELAY; s++) begin
        vld_n[s]  = vld_q[s-1];
        bank_n[s] = bank_q[s-1];
        row_n[s]  = row_q[s-1];
        fwd_n[s]  = fwd_q[s-1];
        data_n[s] = data_q[s-1];
      end
      // a write to the same word supersedes whatever the bank will return
      for (int s = 0; s < SRAM_DELAY; s++) begin
        if (wr_en && vld_n[s] && (wr_bank == bank_n[s]) && (wr_row == row_n[s])) begin
          fwd_n[s]  = 1'b1;
          data_n[s] = wr_data;
        end
      end
    end

    always_ff @(posedge clk) begin
      for (int s = 0; s < SRAM_DELAY; s++) begin
        bank_q[s] <= bank_n[s];
        row_q[s]  <= row_n[s];
        data_q[s] <= data_n[s];
        if (rst) begin
          vld_q[s] <= 1'b0;
          fwd_q[s] <= 1'b0;
        end else begin
          vld_q[s] <= vld_n[s];
          fwd_q[s] <= fwd_n[s];
        end
      end
    end

    assign trk_valid[p] = vld_q[SRAM_DELAY-1];
    assign trk_bank[p]  = bank_q[SRAM_DELAY-1];
    assign trk_fwd[p]   = fwd_q[SRAM_DELAY-1];
    assign trk_data[p]  = data_q[SRAM_DELAY-1];

  end

endmodule

/* verilog/read_merge.sv */
`timescale 1ns/10ps

module read_merge #(
  parameter int NUM_RD_PORTS = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  mem_pkg::data_t bank_dout  [NUM_RD_PORTS][mem_pkg::NUM_BANKS],
  input  logic           trk_valid  [NUM_RD_PORTS],
  input  mem_pkg::bank_t trk_bank   [NUM_RD_PORTS],
  input  logic           trk_fwd    [NUM_RD_PORTS],
  input  mem_pkg::data_t trk_data   [NUM_RD_PORTS],
  output logic           resp_valid [NUM_RD_PORTS],
  output mem_pkg::data_t resp_data  [NUM_RD_PORTS],
  output logic           resp_fwd   [NUM_RD_PORTS]
);

  mem_pkg::data_t pick [NUM_RD_PORTS];

  // forwarded data wins over the replica of the addressed bank
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      pick[p] = trk_fwd[p] ? trk_data[p] : bank_dout[p][trk_bank[p]];
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      resp_data[p] <= pick[p];
      if (rst) begin
        resp_valid[p] <= 1'b0;
        resp_fwd[p]   <= 1'b0;
      end else begin
        resp_valid[p] <= trk_valid[p];
        resp_fwd[p]   <= trk_fwd[p];
      end
    end
  end

endmodule

/* verilog/mem_core_top.sv */
`timescale 1ns/10ps

module mem_core_top #(
  parameter int SRAM_DELAY   = 2,
  parameter int NUM_RD_PORTS = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr_valid,
  input  mem_pkg::addr_t wr_addr,
  input  mem_pkg::data_t wr_data,
  input  logic           rd_valid   [NUM_RD_PORTS],
  input  mem_pkg::addr_t rd_addr    [NUM_RD_PORTS],
  output logic           ready,
  output logic           resp_valid [NUM_RD_PORTS],
  output mem_pkg::data_t resp_data  [NUM_RD_PORTS],
  output logic           resp_fwd   [NUM_RD_PORTS]
);

  localparam int ROW_BITS  = mem_pkg::ROW_BITS;
  localparam int ADDR_BITS = mem_pkg::ADDR_BITS;

  logic           init_write;
  mem_pkg::row_t  init_row;

  logic           wr_acc;
  mem_pkg::bank_t wr_bank;
  mem_pkg::row_t  wr_row;
  logic           rd_acc  [NUM_RD_PORTS];
  mem_pkg::bank_t rd_bank [NUM_RD_PORTS];
  mem_pkg::row_t  rd_row  [NUM_RD_PORTS];

  mem_pkg::data_t bank_dout [NUM_RD_PORTS][mem_pkg::NUM_BANKS];
  logic           trk_valid [NUM_RD_PORTS];
  mem_pkg::bank_t trk_bank  [NUM_RD_PORTS];
  logic           trk_fwd   [NUM_RD_PORTS];
  mem_pkg::data_t trk_data  [NUM_RD_PORTS];

  // requests only count once the sweep has finished
  assign wr_acc  = wr_valid && ready;
  assign wr_bank = wr_addr[ADDR_BITS-1:ROW_BITS];
  assign wr_row  = wr_addr[ROW_BITS-1:0];

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_acc[p]  = rd_valid[p] && ready;
      rd_bank[p] = rd_addr[p][ADDR_BITS-1:ROW_BITS];
      rd_row[p]  = rd_addr[p][ROW_BITS-1:0];
    end
  end

  bank_init u_init (
    .clk, .rst, .ready, .init_write, .init_row
  );

  bank_array #(.SRAM_DELAY(SRAM_DELAY), .NUM_RD_PORTS(NUM_RD_PORTS)) u_array (
    .clk, .init_write, .init_row,
    .wr_en(wr_acc), .wr_bank, .wr_row, .wr_data,
    .rd_en(rd_acc), .rd_bank, .rd_row, .bank_dout
  );

  read_tracker #(.SRAM_DELAY(SRAM_DELAY), .NUM_RD_PORTS(NUM_RD_PORTS)) u_tracker (
    .clk, .rst,
    .rd_en(rd_acc), .rd_bank, .rd_row,
    .wr_en(wr_acc), .wr_bank, .wr_row, .wr_data,
    .trk_valid, .trk_bank, .trk_fwd, .trk_data
  );

  read_merge #(.NUM_RD_PORTS(NUM_RD_PORTS)) u_merge (
    .clk, .rst, .bank_dout, .trk_valid, .trk_bank, .trk_fwd, .trk_data,
    .resp_valid, .resp_data, .resp_fwd
  );

endmodule

/* tb/mem_core_checker.sv */
`timescale 1ns/10ps

module mem_core_checker #(
  parameter int NUM_RD_PORTS = 2
) (
  input logic clk,
  input logic rst,
  input logic ready,
  input logic resp_valid [NUM_RD_PORTS],
  input logic resp_fwd   [NUM_RD_PORTS]
);

  // ready only drops when reset pulls the core back into the sweep
  assert property (@(posedge clk) $fell(ready) |-> $past(rst))
    else $error("ready fell while reset was low");

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port
    assert property (@(posedge clk) disable iff (rst) resp_fwd[p] |-> resp_valid[p])
      else $error("port %0d raised resp_fwd without resp_valid", p);
    // nothing is accepted before the sweep ends, so nothing can come out
    assert property (@(posedge clk) disable iff (rst) !ready |-> !resp_valid[p])
      else $error("port %0d gave a response while ready was low", p);
  end

endmodule

bind mem_core_top mem_core_checker #(.NUM_RD_PORTS(NUM_RD_PORTS)) u_checker (
  .clk(clk), .rst(rst), .ready(ready), .resp_valid(resp_valid), .resp_fwd(resp_fwd)
);

/* tb/tb_mem_core.sv */
`timescale 1ns/10ps

module tb_mem_core;

  localparam int    SRAM_DELAY    = 2;
  localparam int    NUM_RD_PORTS  = 2;
  localparam int    READY_TIMEOUT = 100;
  localparam string INPUT_FILE    = "tb/mem_core_input.txt";

  logic           clk;
  logic           rst;
  logic           wr_valid;
  mem_pkg::addr_t wr_addr;
  mem_pkg::data_t wr_data;
  logic           rd_valid   [NUM_RD_PORTS];
  mem_pkg::addr_t rd_addr    [NUM_RD_PORTS];
  logic           ready;
  logic           resp_valid [NUM_RD_PORTS];
  mem_pkg::data_t resp_data  [NUM_RD_PORTS];
  logic           resp_fwd   [NUM_RD_PORTS];

  int value_errors;
  int other_errors;
  int edge_idx;

  // expected responses, ordered by the edge after which they must show
  int             due_q  [$];
  int             port_q [$];
  string          name_q [$];
  mem_pkg::data_t data_q [$];
  logic           fwd_q  [$];

  mem_core_top #(.SRAM_DELAY(SRAM_DELAY), .NUM_RD_PORTS(NUM_RD_PORTS)) UUT (
    .clk, .rst, .wr_valid, .wr_addr, .wr_data, .rd_valid, .rd_addr,
    .ready, .resp_valid, .resp_data, .resp_fwd
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_data(input string name, input mem_pkg::data_t exp,
                            input mem_pkg::data_t act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic drive_idle();
    wr_valid <= 1'b0;
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_valid[p] <= 1'b0;
    end
  endtask

  task automatic check_responses(input int idx);
    logic  hit [NUM_RD_PORTS];
    int    p;
    string name;
    for (int k = 0; k < NUM_RD_PORTS; k++) begin
      hit[k] = 1'b0;
    end
    while (due_q.size() > 0 && due_q[0] == idx) begin
      void'(due_q.pop_front());
      p      = port_q.pop_front();
      name   = $sformatf("%s port %0d", name_q.pop_front(), p);
      hit[p] = 1'b1;
      check_data({name, " data"}, data_q.pop_front(), resp_data[p]);
      check_flag({name, " fwd"}, fwd_q.pop_front(), resp_fwd[p]);
    end
    for (int k = 0; k < NUM_RD_PORTS; k++) begin
      check_flag($sformatf("resp_valid port %0d edge %0d", k, idx), hit[k], resp_valid[k]);
    end
  endtask

  task automatic wait_ready(output bit ok);
    int cnt;
    cnt = 0;
    while (ready !== 1'b1 && cnt < READY_TIMEOUT) begin
      @(posedge clk);
      cnt++;
      // stop requesting well before the sweep ends
      if (cnt == mem_pkg::NUM_ROWS / 2) begin
        drive_idle();
      end
      @(negedge clk);
      check_flag("ready_timing", cnt >= mem_pkg::NUM_ROWS, ready);
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        check_flag("no_resp_before_ready", 1'b0, resp_valid[p]);
      end
    end
    ok = (ready === 1'b1);
    if (!ok) begin
      other_errors++;
      $display("timeout: ready did not rise within %0d cycles after reset", READY_TIMEOUT);
    end
  endtask

  task automatic run_file();
    int             fd;
    int             n;
    int             drain;
    string          line;
    string          name;
    logic           wv;
    mem_pkg::addr_t wa;
    mem_pkg::data_t wd;
    logic           rv [NUM_RD_PORTS];
    mem_pkg::addr_t ra [NUM_RD_PORTS];
    mem_pkg::data_t ed [NUM_RD_PORTS];
    logic           ef [NUM_RD_PORTS];
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the stimulus file %s", INPUT_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, wv, wa, wd,
                  rv[0], ra[0], ed[0], ef[0], rv[1], ra[1], ed[1], ef[1]);
      if (n != 12) begin
        other_errors++;
        $display("malformed stimulus line: %s", line);
        continue;
      end
      @(posedge clk);
      edge_idx++;
      wr_valid <= wv;
      wr_addr  <= wa;
      wr_data  <= wd;
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        rd_valid[p] <= rv[p];
        rd_addr[p]  <= ra[p];
        if (rv[p] === 1'b1) begin
          due_q.push_back(edge_idx + SRAM_DELAY + 1);
          port_q.push_back(p);
          name_q.push_back(name);
          data_q.push_back(ed[p]);
          fwd_q.push_back(ef[p]);
        end
      end
      @(negedge clk);
      check_responses(edge_idx);
    end
    $fclose(fd);
    // let the last reads leave the pipeline
    drain = 0;
    while (due_q.size() > 0 && drain < SRAM_DELAY + 2) begin
      @(posedge clk);
      edge_idx++;
      drain++;
      drive_idle();
      @(negedge clk);
      check_responses(edge_idx);
    end
    if (due_q.size() > 0) begin
      other_errors++;
      $display("timeout: %0d expected responses never arrived", due_q.size());
    end
  endtask

  task automatic finish_run();
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    value_errors = 0;
    other_errors = 0;
    edge_idx     = 0;
    rst          <= 1'b1;
    wr_valid     <= 1'b0;
    wr_addr      <= '0;
    wr_data      <= '0;
    // both ports request from the start, and none of these may be served
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_valid[p] <= 1'b1;
      rd_addr[p]  <= mem_pkg::addr_t'(p * 17);
    end
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (i == 4) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_flag("ready_in_reset", 1'b0, ready);
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        check_flag("no_resp_in_reset", 1'b0, resp_valid[p]);
      end
    end
    wait_ready(ok);
    if (ok) begin
      run_file();
    end
    finish_run();
  end

endmodule

/* tb.f */
verilog/mem_pkg.sv
verilog/bank_init.sv
verilog/bank_array.sv
verilog/read_tracker.sv
verilog/read_merge.sv
verilog/mem_core_top.sv
tb/mem_core_checker.sv
tb/tb_mem_core.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_mem_core -f tb.f

result=$(./obj_dir/Vtb_mem_core 2>&1) || true
echo "$result"
if grep -qx "all tests passed" <<< "$result"; then
  exit 0
fi
exit 1

/* tb/mem_core_input.txt */
# name wr_valid wr_addr wr_data, then per read port: rd_valid rd_addr exp_data exp_fwd
# all values hex, one line per clock cycle, expectations belong to the read on the same line
cleared_a      0 00 0000  1 00 0000 0  1 3f 0000 0
cleared_b      0 00 0000  1 15 0000 0  1 2a 0000 0
write_plain    1 12 beef  0 00 0000 0  0 00 0000 0
idle_a         0 00 0000  0 00 0000 0  0 00 0000 0
read_plain     0 00 0000  1 12 beef 0  1 00 0000 0
fwd_same       1 21 1111  1 21 1111 1  0 00 0000 0
fwd_next       0 00 0000  1 30 2222 1  1 21 1111 0
fwd_other_row  1 30 2222  0 00 0000 0  1 31 0000 0
fwd_latest     1 05 aaaa  1 05 bbbb 1  1 05 bbbb 1
fwd_latest_b   1 05 bbbb  0 00 0000 0  0 00 0000 0
late_write     1 36 3333  1 0a 0000 0  1 36 3333 1
idle_read      0 00 0000  1 36 3333 0  1 30 2222 0
late_write_b   1 0a cccc  0 00 0000 0  0 00 0000 0
par_same_bank  0 00 0000  1 0a cccc 0  1 05 bbbb 0
par_diff_bank  1 3f dddd  1 12 beef 0  1 21 1111 0
fwd_overwrite  1 3f eeee  1 3f eeee 1  1 12 beef 0
after_fwd      0 00 0000  1 3f eeee 0  1 30 2222 0
fwd_rewrite    1 12 0123  1 12 0123 1  1 2a 0000 0
read_rewrite   0 00 0000  1 12 0123 0  0 00 0000 0
